/* gat_config.svh */
// GAT score stage sizes
`ifndef GAT_CONFIG_SVH
`define GAT_CONFIG_SVH

// ======================================================================
// Node vector and coefficients
// ======================================================================
`define GAT_NUM_FEATURE      4
`define GAT_DATA_WIDTH       8
`define GAT_MAX_NODES        8

// Coefficient address, upper bit picks the neighbor half
`define GAT_COEF_ADDR_WIDTH  3

// ======================================================================
// Arithmetic widths
// ======================================================================
`define GAT_PROD_WIDTH       16
// Four products summed
`define GAT_DOT_WIDTH        18
// Source dot plus neighbor dot
`define GAT_SCORE_WIDTH      19

`define GAT_NODE_IDX_WIDTH   3

// Negative slope of one quarter
`define GAT_LRELU_SHIFT      2

`endif

/* gat_pkg.sv */
// GAT score stage types
`include "gat_config.svh"

package gat_pkg;

  // ======================================================================
  // Feature words
  // ======================================================================
  typedef logic signed [`GAT_DATA_WIDTH-1:0] feat_t;

  // Wh vectors and both attention halves
  typedef feat_t [`GAT_NUM_FEATURE-1:0] feat_vec_t;

  typedef struct packed {
    feat_vec_t wh;
    logic      first;
    logic      last;
  } node_in_t;

  // Addresses 0..3 source half, 4..7 neighbor half
  typedef struct packed {
    logic [`GAT_COEF_ADDR_WIDTH-1:0] addr;
    logic signed [`GAT_DATA_WIDTH-1:0] data;
  } coef_wr_t;

  // ======================================================================
  // Results
  // ======================================================================
  typedef logic signed [`GAT_DOT_WIDTH-1:0] dot_t;

  typedef struct packed {
    logic signed [`GAT_SCORE_WIDTH-1:0] score;
    logic [`GAT_NODE_IDX_WIDTH-1:0]     node_idx;
    logic                               last;
  } score_out_t;

  typedef struct packed {
    logic signed [`GAT_SCORE_WIDTH-1:0] max_score;
    logic [`GAT_NODE_IDX_WIDTH-1:0]     node_cnt_m1;
  } subgraph_sum_t;

endpackage

/* gat_coef_regs.sv */
// Attention vector register file
`include "gat_config.svh"

module gat_coef_regs (
  input  logic               clk,
  input  logic               rst_n,

  input  logic               coef_wr_valid,
  input  gat_pkg::coef_wr_t  coef_wr,

  output gat_pkg::feat_vec_t a_src,
  output gat_pkg::feat_vec_t a_nbr
);

  localparam int HALF_IDX_W = `GAT_COEF_ADDR_WIDTH - 1;

  logic                  sel_nbr;
  logic [HALF_IDX_W-1:0] half_idx;
  gat_pkg::feat_vec_t    a_src_q;
  gat_pkg::feat_vec_t    a_nbr_q;

  // Split address into half select and word index
  assign sel_nbr  = coef_wr.addr[`GAT_COEF_ADDR_WIDTH-1];
  assign half_idx = coef_wr.addr[HALF_IDX_W-1:0];

  // ======================================================================
  // Coefficient storage
  // ======================================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      a_src_q <= '0;
      a_nbr_q <= '0;
    end else if (coef_wr_valid) begin
      if (sel_nbr) begin
        a_nbr_q[half_idx] <= coef_wr.data;
      end else begin
        a_src_q[half_idx] <= coef_wr.data;
      end
    end
  end

  // Seen by nodes from the cycle after the write
  assign a_src = a_src_q;
  assign a_nbr = a_nbr_q;

endmodule

/* gat_dot_product.sv */
// Pipelined dot product for one attention half
`include "gat_config.svh"

module gat_dot_product (
  input  logic               clk,
  input  logic               rst_n,

  input  logic               in_valid,
  input  gat_pkg::node_in_t  in_node,
  input  gat_pkg::feat_vec_t coef,

  output logic               out_valid,
  output gat_pkg::dot_t      out_dot,
  output logic               out_first,
  output logic               out_last
);

  logic signed [`GAT_PROD_WIDTH-1:0] prod_q [`GAT_NUM_FEATURE];
  logic                              prod_valid_q;
  logic                              prod_first_q;
  logic                              prod_last_q;
  gat_pkg::dot_t                     prod_sum;

  // ======================================================================
  // Stage 1: element products
  // ======================================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prod_valid_q <= 1'b0;
    end else begin
      prod_valid_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      for (int i = 0; i < `GAT_NUM_FEATURE; i++) begin
        prod_q[i] <= $signed(in_node.wh[i]) * $signed(coef[i]);
      end
      prod_first_q <= in_node.first;
      prod_last_q  <= in_node.last;
    end
  end

  // ======================================================================
  // Stage 2: adder tree
  // ======================================================================
  // Products sign-extend to the dot width before summing
  always_comb begin
    prod_sum = '0;
    for (int i = 0; i < `GAT_NUM_FEATURE; i++) begin
      prod_sum = prod_sum + prod_q[i];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= prod_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid_q) begin
      out_dot   <= prod_sum;
      out_first <= prod_first_q;
      out_last  <= prod_last_q;
    end
  end

endmodule

/* gat_score_combine.sv */
// Score sum, LeakyReLU and subgraph summary
`include "gat_config.svh"

module gat_score_combine (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   src_valid,
  input  gat_pkg::dot_t          src_dot,
  input  logic                   nbr_valid,
  input  gat_pkg::dot_t          nbr_dot,
  input  logic                   first,
  input  logic                   last,

  output logic                   score_valid,
  output gat_pkg::score_out_t    score_out,
  output logic                   sum_valid,
  output gat_pkg::subgraph_sum_t subgraph_sum
);

  logic                               node_valid;
  gat_pkg::dot_t                      src_dot_q;
  gat_pkg::dot_t                      src_term;
  logic signed [`GAT_SCORE_WIDTH-1:0] score_raw;
  logic signed [`GAT_SCORE_WIDTH-1:0] score_lrelu;
  logic signed [`GAT_SCORE_WIDTH-1:0] max_q;
  logic signed [`GAT_SCORE_WIDTH-1:0] cur_max;
  logic [`GAT_NODE_IDX_WIDTH-1:0]     idx_q;
  logic [`GAT_NODE_IDX_WIDTH-1:0]     cur_idx;

  // Both halves run in lockstep
  assign node_valid = src_valid & nbr_valid;

  // ======================================================================
  // Source term and score
  // ======================================================================
  // First node supplies the source term directly
  assign src_term = first ? src_dot : src_dot_q;

  always_ff @(posedge clk) begin
    if (node_valid && first) begin
      src_dot_q <= src_dot;
    end
  end

  assign score_raw   = src_term + nbr_dot;
  // Arithmetic shift rounds odd negatives down
  assign score_lrelu = score_raw[`GAT_SCORE_WIDTH-1] ?
                       (score_raw >>> `GAT_LRELU_SHIFT) : score_raw;

  // ======================================================================
  // Node index and running maximum
  // ======================================================================
  assign cur_idx = first ? '0 : idx_q;
  assign cur_max = (first || (score_lrelu > max_q)) ? score_lrelu : max_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idx_q <= '0;
      max_q <= '0;
    end else if (node_valid) begin
      idx_q <= cur_idx + 1'b1;
      max_q <= cur_max;
    end
  end

  // ======================================================================
  // Output registers
  // ======================================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      score_valid <= 1'b0;
      sum_valid   <= 1'b0;
    end else begin
      score_valid <= node_valid;
      sum_valid   <= node_valid & last;
    end
  end

  always_ff @(posedge clk) begin
    if (node_valid) begin
      score_out.score    <= score_lrelu;
      score_out.node_idx <= cur_idx;
      score_out.last     <= last;
    end
    // Summary only moves on the closing node
    if (node_valid && last) begin
      subgraph_sum.max_score   <= cur_max;
      subgraph_sum.node_cnt_m1 <= cur_idx;
    end
  end

endmodule

/* gat_score_top.sv */
// GAT attention score core
module gat_score_top (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   coef_wr_valid,
  input  gat_pkg::coef_wr_t      coef_wr,

  input  logic                   node_valid,
  input  gat_pkg::node_in_t      node_in,

  output logic                   score_valid,
  output gat_pkg::score_out_t    score_out,
  output logic                   sum_valid,
  output gat_pkg::subgraph_sum_t subgraph_sum
);

  gat_pkg::feat_vec_t a_src;
  gat_pkg::feat_vec_t a_nbr;

  logic               src_valid;
  gat_pkg::dot_t      src_dot;
  logic               src_first;
  logic               src_last;
  logic               nbr_valid;
  gat_pkg::dot_t      nbr_dot;

  // ======================================================================
  // Attention vector
  // ======================================================================
  gat_coef_regs u_coef_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .coef_wr_valid (coef_wr_valid),
    .coef_wr       (coef_wr),
    .a_src         (a_src),
    .a_nbr         (a_nbr)
  );

  // ======================================================================
  // Dot products, latency 2
  // ======================================================================
  gat_dot_product u_dot_src (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (node_valid),
    .in_node   (node_in),
    .coef      (a_src),
    .out_valid (src_valid),
    .out_dot   (src_dot),
    .out_first (src_first),
    .out_last  (src_last)
  );

  // Flags taken from the source side
  gat_dot_product u_dot_nbr (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (node_valid),
    .in_node   (node_in),
    .coef      (a_nbr),
    .out_valid (nbr_valid),
    .out_dot   (nbr_dot),
    .out_first (),
    .out_last  ()
  );

  gat_score_combine u_combine (
    .clk          (clk),
    .rst_n        (rst_n),
    .src_valid    (src_valid),
    .src_dot      (src_dot),
    .nbr_valid    (nbr_valid),
    .nbr_dot      (nbr_dot),
    .first        (src_first),
    .last         (src_last),
    .score_valid  (score_valid),
    .score_out    (score_out),
    .sum_valid    (sum_valid),
    .subgraph_sum (subgraph_sum)
  );

endmodule

/* tb_gat_score_model.svh */
// GAT score reference model
`ifndef TB_GAT_SCORE_MODEL_SVH
`define TB_GAT_SCORE_MODEL_SVH

// Shared with tb_gat_score through module scope
int model_src [`GAT_NUM_FEATURE] = '{default: 0};
int model_nbr [`GAT_NUM_FEATURE] = '{default: 0};
int model_src_dot;
int model_idx;
int model_max;

gat_pkg::score_out_t    exp_score_q [$];
gat_pkg::subgraph_sum_t exp_sum_q [$];

// ======================================================================
// Reference arithmetic
// ======================================================================
function automatic void model_coef_write(input gat_pkg::coef_wr_t w);
  int idx;
  idx = w.addr % `GAT_NUM_FEATURE;
  if (w.addr >= `GAT_NUM_FEATURE) begin
    model_nbr[idx] = w.data;
  end else begin
    model_src[idx] = w.data;
  end
endfunction

function automatic int model_dot(input gat_pkg::feat_vec_t wh,
                                 input int coef [`GAT_NUM_FEATURE]);
  int sum;
  sum = 0;
  for (int i = 0; i < `GAT_NUM_FEATURE; i++) begin
    sum += int'(wh[i]) * coef[i];
  end
  return sum;
endfunction

// Slope of one quarter with rounding toward negative infinity
function automatic int model_lrelu(input int raw);
  int div;
  div = 1 << `GAT_LRELU_SHIFT;
  if (raw >= 0) begin
    return raw;
  end
  return (raw - div + 1) / div;
endfunction

function automatic void model_node(input gat_pkg::node_in_t n);
  int                     nbr_dot;
  int                     score;
  gat_pkg::score_out_t    s;
  gat_pkg::subgraph_sum_t m;
  if (n.first) begin
    model_src_dot = model_dot(n.wh, model_src);
    model_idx     = 0;
  end else begin
    model_idx++;
  end
  nbr_dot = model_dot(n.wh, model_nbr);
  score   = model_lrelu(model_src_dot + nbr_dot);
  if (n.first || score > model_max) begin
    model_max = score;
  end
  s.score    = score[`GAT_SCORE_WIDTH-1:0];
  s.node_idx = model_idx[`GAT_NODE_IDX_WIDTH-1:0];
  s.last     = n.last;
  exp_score_q.push_back(s);
  if (n.last) begin
    m.max_score   = model_max[`GAT_SCORE_WIDTH-1:0];
    m.node_cnt_m1 = model_idx[`GAT_NODE_IDX_WIDTH-1:0];
    exp_sum_q.push_back(m);
  end
endfunction

// ======================================================================
// Compare tasks
// ======================================================================
task automatic check_score(input string name, input gat_pkg::score_out_t exp,
                           input gat_pkg::score_out_t act);
  if (act !== exp) begin
    fail_run($sformatf(
      "ERROR %s: score expected %0d idx %0d last %0b, actual %0d idx %0d last %0b",
      name, exp.score, exp.node_idx, exp.last,
      act.score, act.node_idx, act.last));
  end
endtask

task automatic check_sum(input string name, input gat_pkg::subgraph_sum_t exp,
                         input gat_pkg::subgraph_sum_t act);
  if (act !== exp) begin
    fail_run($sformatf(
      "ERROR %s: sum expected max %0d count-1 %0d, actual max %0d count-1 %0d",
      name, exp.max_score, exp.node_cnt_m1,
      act.max_score, act.node_cnt_m1));
  end
endtask

`endif

/* tb_gat_score.sv */
// GAT score stage testbench
`include "gat_config.svh"

module tb_gat_score;

  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 5;
  localparam int ZERO_SUBGRAPHS = 4;
  localparam int RAND_SUBGRAPHS = 40;
  localparam int GAP_SUBGRAPHS  = 30;
  localparam int ODD_NODES      = 5;
  localparam int MAX_NODES      =
    (ZERO_SUBGRAPHS + RAND_SUBGRAPHS + GAP_SUBGRAPHS) * `GAT_MAX_NODES + ODD_NODES;
  localparam int TIMEOUT_CYCLES = MAX_NODES * 4 + 200;
  // Pipeline latency of 3 plus margin
  localparam int DRAIN_CYCLES   = 8;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   coef_wr_valid;
  gat_pkg::coef_wr_t      coef_wr;
  logic                   node_valid;
  gat_pkg::node_in_t      node_in;
  logic                   score_valid;
  gat_pkg::score_out_t    score_out;
  logic                   sum_valid;
  gat_pkg::subgraph_sum_t subgraph_sum;

  int    seed      = 41964;
  string test_name = "reset";

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped on a failed check");
  endtask

  `include "tb_gat_score_model.svh"

  gat_score_top u_gat_score_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .coef_wr_valid (coef_wr_valid),
    .coef_wr       (coef_wr),
    .node_valid    (node_valid),
    .node_in       (node_in),
    .score_valid   (score_valid),
    .score_out     (score_out),
    .sum_valid     (sum_valid),
    .subgraph_sum  (subgraph_sum)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    fail_run($sformatf("Timeout after %0d cycles waiting for DUT results", TIMEOUT_CYCLES));
  end

  // ======================================================================
  // Random values and stimulus
  // ======================================================================
  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return lo + (r % (hi - lo + 1));
  endfunction

  function automatic gat_pkg::feat_t rand_word();
    int r;
    r = $random(seed);
    return r[`GAT_DATA_WIDTH-1:0];
  endfunction

  function automatic gat_pkg::feat_vec_t rand_vec();
    gat_pkg::feat_vec_t v;
    for (int i = 0; i < `GAT_NUM_FEATURE; i++) begin
      v[i] = rand_word();
    end
    return v;
  endfunction

  // Word 0 fixed and the rest random
  function automatic gat_pkg::feat_vec_t lead_vec(input int word0);
    gat_pkg::feat_vec_t v;
    v    = rand_vec();
    v[0] = word0[`GAT_DATA_WIDTH-1:0];
    return v;
  endfunction

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      node_valid    <= 1'b0;
      coef_wr_valid <= 1'b0;
    end
  endtask

  task automatic write_coef(input int addr, input gat_pkg::feat_t data);
    gat_pkg::coef_wr_t w;
    w.addr = addr[`GAT_COEF_ADDR_WIDTH-1:0];
    w.data = data;
    @(posedge clk);
    node_valid    <= 1'b0;
    coef_wr_valid <= 1'b1;
    coef_wr       <= w;
    model_coef_write(w);
  endtask

  task automatic send_node(input gat_pkg::feat_vec_t wh, input logic first, input logic last);
    gat_pkg::node_in_t n;
    n.wh    = wh;
    n.first = first;
    n.last  = last;
    @(posedge clk);
    coef_wr_valid <= 1'b0;
    node_valid    <= 1'b1;
    node_in       <= n;
    model_node(n);
  endtask

  task automatic send_subgraph(input int nodes, input int max_gap);
    for (int i = 0; i < nodes; i++) begin
      send_node(rand_vec(), i == 0, i == nodes - 1);
      idle(rand_range(0, max_gap));
    end
  endtask

  // Wait until every expected result has come out
  task automatic drain();
    int waited;
    waited = 0;
    idle(1);
    while ((exp_score_q.size() != 0 || exp_sum_q.size() != 0) && waited < DRAIN_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (exp_score_q.size() != 0 || exp_sum_q.size() != 0) begin
      fail_run("Expected results were still missing after the pipeline emptied");
    end
    idle(2);
  endtask

  // ======================================================================
  // Output monitor
  // ======================================================================
  always @(negedge clk) begin : monitor
    gat_pkg::score_out_t    exp_score;
    gat_pkg::subgraph_sum_t exp_sum;
    if (!rst_n) begin
      if (score_valid !== 1'b0 || sum_valid !== 1'b0) begin
        fail_run("A valid output was high during reset");
      end
    end else if (sum_valid && !(score_valid && score_out.last)) begin
      fail_run("sum_valid arrived without the last score of the subgraph");
    end else if (score_valid && score_out.last && !sum_valid) begin
      fail_run("The last score of a subgraph arrived without sum_valid");
    end else if (score_valid && exp_score_q.size() == 0) begin
      fail_run("A score strobe arrived while no score was expected");
    end else if (sum_valid && exp_sum_q.size() == 0) begin
      fail_run("A subgraph summary arrived while none was expected");
    end else begin
      if (score_valid) begin
        exp_score = exp_score_q.pop_front();
        check_score(test_name, exp_score, score_out);
      end
      if (sum_valid) begin
        exp_sum = exp_sum_q.pop_front();
        check_sum(test_name, exp_sum, subgraph_sum);
      end
    end
  end

  // ======================================================================
  // Test sequence
  // ======================================================================
  initial begin
    rst_n         = 1'b0;
    coef_wr_valid = 1'b0;
    coef_wr       = '0;
    node_valid    = 1'b0;
    node_in       = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    test_name = "zero_coef";
    for (int sg = 0; sg < ZERO_SUBGRAPHS; sg++) begin
      send_subgraph(rand_range(1, `GAT_MAX_NODES), 0);
    end
    drain();

    // Score is word 0 of source plus word 0 of neighbor
    test_name = "lrelu_odd";
    write_coef(0, 8'sd1);
    write_coef(`GAT_NUM_FEATURE, 8'sd1);
    send_node(lead_vec(-3), 1'b1, 1'b0);
    send_node(lead_vec(2), 1'b0, 1'b0);
    send_node(lead_vec(0), 1'b0, 1'b0);
    send_node(lead_vec(-4), 1'b0, 1'b0);
    send_node(lead_vec(10), 1'b0, 1'b1);
    drain();

    test_name = "random_b2b";
    for (int a = 0; a < 2 * `GAT_NUM_FEATURE; a++) begin
      write_coef(a, rand_word());
    end
    for (int sg = 0; sg < RAND_SUBGRAPHS; sg++) begin
      send_subgraph(rand_range(1, `GAT_MAX_NODES), 0);
    end
    drain();

    test_name = "gaps_rewrite";
    for (int sg = 0; sg < GAP_SUBGRAPHS; sg++) begin
      if (sg % 5 == 0) begin
        write_coef(rand_range(0, 2 * `GAT_NUM_FEATURE - 1), rand_word());
        write_coef(rand_range(0, 2 * `GAT_NUM_FEATURE - 1), rand_word());
        idle(rand_range(0, 2));
      end
      send_subgraph((sg % 4 == 0) ? 1 : rand_range(1, `GAT_MAX_NODES), 2);
    end
    drain();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+.
gat_pkg.sv
gat_coef_regs.sv
gat_dot_product.sv
gat_score_combine.sv
gat_score_top.sv
tb_gat_score.sv

/* Bender.yml */
package:
  name: gat_score

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - gat_pkg.sv
      - gat_coef_regs.sv
      - gat_dot_product.sv
      - gat_score_combine.sv
      - gat_score_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_gat_score.sv
